// File: hdl/router_pkg.sv
package router_pkg;

	// sizes
	localparam int DATA_BITS = 8; // item width
	localparam int PORT_COUNT = 5; // transmit ports
	localparam int DEST_BITS = 3; // port index width
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_CNT_BITS = 4; // holds 0..FIFO_DEPTH
	localparam int FIFO_PTR_BITS = 3; // wraps naturally at FIFO_DEPTH
	localparam int TABLE_DEPTH = 256; // one entry per item value

	// register index, taken from wishbone address bits [3:2]
	localparam logic [1:0] ADDR_ITEM = 2'd0; // item push
	localparam logic [1:0] ADDR_ROUTE = 2'd1; // table write
	localparam logic [1:0] ADDR_STATUS = 2'd2; // status read

	// dispatcher states
	localparam logic ST_IDLE = 1'b0;
	localparam logic ST_LOOKUP = 1'b1;

	// one write data word, read as an item or as a table entry
	typedef union packed {
		struct packed {
			logic [23:0] pad;
			logic [DATA_BITS-1:0] value;
		} item;
		struct packed {
			logic [12:0] pad;
			logic [DATA_BITS-1:0] addr; // table index = item value
			logic [7:0] spare;
			logic [DEST_BITS-1:0] dest;
		} route;
	} wb_word_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [3:0] adr; // byte address, word select in [3:2]
		wb_word_t dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [31:0] dat;
	} wb_rsp_t;

	typedef struct packed {
		logic en;
		logic [DATA_BITS-1:0] addr;
		logic [DEST_BITS-1:0] dest;
	} route_wr_t;

	typedef struct packed {
		logic req; // 2-phase toggle
		logic [DATA_BITS-1:0] data; // held while req outstanding
	} tx_req_t;

endpackage

// File: hdl/wb_ingress.sv
module wb_ingress (
	input logic clk,
	input logic reset,
	input router_pkg::wb_req_t wb_in,
	output router_pkg::wb_rsp_t wb_out,
	input logic fifo_full,
	input logic [router_pkg::FIFO_CNT_BITS-1:0] fifo_count,
	input logic [router_pkg::PORT_COUNT-1:0] port_busy,
	output logic push,
	output logic [router_pkg::DATA_BITS-1:0] push_data,
	output router_pkg::route_wr_t route_wr
);
	import router_pkg::*;

	logic [1:0] reg_sel;
	logic access; // live cycle not yet acked
	logic is_item;
	logic is_route;
	logic accept;
	logic [31:0] status_word;
	logic ack_q;
	logic [31:0] rdat_q;
	logic route_en_q;
	logic [DATA_BITS-1:0] route_addr_q;
	logic [DEST_BITS-1:0] route_dest_q;

	assign reg_sel = wb_in.adr[3:2];
	assign access = wb_in.cyc & wb_in.stb & ~ack_q; // ~ack_q keeps ack to one cycle
	assign is_item = wb_in.we & (reg_sel == ADDR_ITEM);
	assign is_route = wb_in.we & (reg_sel == ADDR_ROUTE);
	assign accept = access & ~(is_item & fifo_full); // full fifo -> wait states

	// status layout: count low, busy vector above it
	always_comb begin
		status_word = '0;
		status_word[FIFO_CNT_BITS-1:0] = fifo_count;
		status_word[FIFO_CNT_BITS +: PORT_COUNT] = port_busy;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ack_q <= 1'b0;
			push <= 1'b0;
			route_en_q <= 1'b0;
		end else begin
			ack_q <= accept; // registered ack, one cycle
			push <= accept & is_item;
			route_en_q <= accept & is_route;
		end
	end

	// payload follows the accepted word
	always_ff @(posedge clk) begin
		if (accept) begin
			push_data <= wb_in.dat.item.value; // item view
			route_addr_q <= wb_in.dat.route.addr; // route view of same word
			route_dest_q <= wb_in.dat.route.dest;
			rdat_q <= (reg_sel == ADDR_STATUS) ? status_word : '0;
		end
	end

	assign wb_out = '{ack: ack_q, dat: rdat_q};
	assign route_wr = '{en: route_en_q, addr: route_addr_q, dest: route_dest_q};

	// host sees each ack for a single cycle only
	ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
		wb_out.ack |=> !wb_out.ack);

endmodule

// File: hdl/item_fifo.sv
module item_fifo (
	input logic clk,
	input logic reset,
	input logic push,
	input logic [router_pkg::DATA_BITS-1:0] push_data,
	input logic pop,
	output logic [router_pkg::DATA_BITS-1:0] head,
	output logic empty,
	output logic full,
	output logic [router_pkg::FIFO_CNT_BITS-1:0] count
);
	import router_pkg::*;

	logic [DATA_BITS-1:0] mem [FIFO_DEPTH];
	logic [FIFO_PTR_BITS-1:0] wr_ptr;
	logic [FIFO_PTR_BITS-1:0] rd_ptr;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	assign head = mem[rd_ptr]; // show-ahead
	assign empty = (count == '0);
	assign full = (count == FIFO_CNT_BITS'(FIFO_DEPTH));

	// ingress checks full a cycle early, dispatcher only pops a looked-up head
	no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full);
	no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

// File: hdl/route_table.sv
module route_table (
	input logic clk,
	input router_pkg::route_wr_t route_wr,
	input logic [router_pkg::DATA_BITS-1:0] lookup_addr,
	output logic [router_pkg::DEST_BITS-1:0] lookup_dest
);
	import router_pkg::*;

	// one destination per item value, no reset
	logic [DEST_BITS-1:0] mem [TABLE_DEPTH];

	// host side write, one entry per route_wr pulse
	always_ff @(posedge clk) begin
		if (route_wr.en)
			mem[route_wr.addr] <= route_wr.dest;
	end

	// lookup_addr comes straight from the dispatcher's address register,
	// so the destination is ready in the cycle after the head was sampled
	assign lookup_dest = mem[lookup_addr];

endmodule

// File: hdl/tx_dispatch.sv
module tx_dispatch (
	input logic clk,
	input logic reset,
	input logic [router_pkg::DATA_BITS-1:0] head,
	input logic empty,
	output logic pop,
	output logic [router_pkg::DATA_BITS-1:0] lookup_addr,
	input logic [router_pkg::DEST_BITS-1:0] lookup_dest,
	output router_pkg::tx_req_t [router_pkg::PORT_COUNT-1:0] tx_req,
	input logic [router_pkg::PORT_COUNT-1:0] tx_ack,
	output logic [router_pkg::PORT_COUNT-1:0] port_busy
);
	import router_pkg::*;

	logic state;
	logic [PORT_COUNT-1:0] req_q; // toggle per port
	logic [PORT_COUNT-1:0] ack_prev;
	logic [PORT_COUNT-1:0] ack_seen; // ack toggled this cycle
	logic [PORT_COUNT-1:0] issue_mask;
	logic [DATA_BITS-1:0] data_q [PORT_COUNT];
	logic dest_ok;
	logic issue;

	assign ack_seen = tx_ack ^ ack_prev;
	assign dest_ok = (lookup_dest < DEST_BITS'(PORT_COUNT));
	// bad destination stalls the queue rather than index past the ports
	assign issue = (state == ST_LOOKUP) && dest_ok && !port_busy[lookup_dest];
	assign pop = issue; // head advances on the same edge as the req toggle

	always_comb begin
		issue_mask = '0;
		if (issue)
			issue_mask[lookup_dest] = 1'b1;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ST_IDLE;
			req_q <= '0;
			ack_prev <= '0;
			port_busy <= '0;
		end else begin
			ack_prev <= tx_ack;
			port_busy <= (port_busy & ~ack_seen) | issue_mask; // clear a cycle after ack
			req_q <= req_q ^ issue_mask; // request = toggle
			case (state)
				ST_IDLE: if (!empty) state <= ST_LOOKUP;
				ST_LOOKUP: if (issue) state <= ST_IDLE; // else wait on busy port
				default: state <= ST_IDLE;
			endcase
		end
	end

	// address register and per-port data have no reset
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && !empty)
			lookup_addr <= head; // item value is the route address
		for (int i = 0; i < PORT_COUNT; i++) begin
			if (issue_mask[i])
				data_q[i] <= head; // stable until the next request
		end
	end

	always_comb begin
		for (int i = 0; i < PORT_COUNT; i++)
			tx_req[i] = '{req: req_q[i], data: data_q[i]};
	end

	// a port never gets a second request before its ack came back
	for (genvar g = 0; g < PORT_COUNT; g++) begin : g_req_chk
		req_when_free: assert property (@(posedge clk) disable iff (reset)
			$changed(req_q[g]) |-> $past(!port_busy[g] && req_q[g] == tx_ack[g]));
	end

	// the host only writes table entries that name real ports
	dest_in_range: assert property (@(posedge clk) disable iff (reset)
		state == ST_LOOKUP |-> dest_ok);

endmodule

// File: hdl/tx_port.sv
module tx_port (
	input logic clk,
	input logic reset,
	input router_pkg::tx_req_t tx_req,
	output logic tx_ack,
	output logic out_valid,
	output logic [router_pkg::DATA_BITS-1:0] out_data,
	input logic out_ready
);
	import router_pkg::*;

	logic req_prev;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			req_prev <= 1'b0;
			tx_ack <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			if (out_valid) begin
				if (out_ready) begin
					out_valid <= 1'b0;
					tx_ack <= ~tx_ack; // 2-phase ack after transfer
				end
			end else if (tx_req.req != req_prev) begin
				req_prev <= tx_req.req;
				out_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!out_valid && tx_req.req != req_prev)
			out_data <= tx_req.data;
	end

endmodule

// File: hdl/router_top.sv
module router_top (
	input logic clk,
	input logic reset,
	input router_pkg::wb_req_t wb_in,
	output router_pkg::wb_rsp_t wb_out,
	output logic [router_pkg::PORT_COUNT-1:0] out_valid,
	output logic [router_pkg::PORT_COUNT-1:0][router_pkg::DATA_BITS-1:0] out_data,
	input logic [router_pkg::PORT_COUNT-1:0] out_ready
);
	import router_pkg::*;

	logic push;
	logic [DATA_BITS-1:0] push_data;
	route_wr_t route_wr;
	logic pop;
	logic [DATA_BITS-1:0] head;
	logic fifo_empty;
	logic fifo_full;
	logic [FIFO_CNT_BITS-1:0] fifo_count;
	logic [DATA_BITS-1:0] lookup_addr;
	logic [DEST_BITS-1:0] lookup_dest;
	tx_req_t [PORT_COUNT-1:0] tx_req;
	logic [PORT_COUNT-1:0] tx_ack;
	logic [PORT_COUNT-1:0] port_busy;

	wb_ingress ingress0 (
		.clk(clk),
		.reset(reset),
		.wb_in(wb_in),
		.wb_out(wb_out),
		.fifo_full(fifo_full),
		.fifo_count(fifo_count),
		.port_busy(port_busy),
		.push(push),
		.push_data(push_data),
		.route_wr(route_wr)
	);

	item_fifo fifo0 (
		.clk(clk),
		.reset(reset),
		.push(push),
		.push_data(push_data),
		.pop(pop),
		.head(head),
		.empty(fifo_empty),
		.full(fifo_full),
		.count(fifo_count)
	);

	route_table table0 (
		.clk(clk),
		.route_wr(route_wr),
		.lookup_addr(lookup_addr),
		.lookup_dest(lookup_dest)
	);

	tx_dispatch dispatch0 (
		.clk(clk),
		.reset(reset),
		.head(head),
		.empty(fifo_empty),
		.pop(pop),
		.lookup_addr(lookup_addr),
		.lookup_dest(lookup_dest),
		.tx_req(tx_req),
		.tx_ack(tx_ack),
		.port_busy(port_busy)
	);

	// one transceiver per output port
	for (genvar p = 0; p < PORT_COUNT; p++) begin : g_port
		tx_port port0 (
			.clk(clk),
			.reset(reset),
			.tx_req(tx_req[p]),
			.tx_ack(tx_ack[p]),
			.out_valid(out_valid[p]),
			.out_data(out_data[p]),
			.out_ready(out_ready[p])
		);
	end

endmodule

// File: tests/router_tb.sv
module router_tb;
	import router_pkg::*;

	localparam int WB_TIMEOUT = 50; // cycles per wishbone access
	localparam int POLL_LIMIT = 200; // status reads before giving up
	localparam int DRAIN_TIMEOUT = 2000;

	logic clk = 1'b0;
	logic reset;
	wb_req_t wb_in;
	wb_rsp_t wb_out;
	logic [PORT_COUNT-1:0] out_valid;
	logic [PORT_COUNT-1:0][DATA_BITS-1:0] out_data;
	logic [PORT_COUNT-1:0] out_ready;
	logic [PORT_COUNT-1:0] ready_mask = '1; // all ones = random ready
	logic [DATA_BITS-1:0] expect_q [PORT_COUNT][$]; // per-port expected items
	int errors = 0;
	int timeouts = 0;

	router_top dut0 (
		.clk(clk),
		.reset(reset),
		.wb_in(wb_in),
		.wb_out(wb_out),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_ready(out_ready)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// one classic cycle held until ack or timeout
	task automatic wb_access(input logic we, input logic [1:0] sel, input logic [31:0] wdata,
			output logic [31:0] rdata);
		int n;
		n = 0;
		@(posedge clk);
		#1;
		wb_in.cyc = 1'b1;
		wb_in.stb = 1'b1;
		wb_in.we = we;
		wb_in.adr = {sel, 2'b00}; // word select on [3:2]
		wb_in.dat = wdata;
		do begin
			@(posedge clk);
			#1;
			n++;
		end while (!wb_out.ack && n < WB_TIMEOUT);
		rdata = wb_out.dat;
		if (!wb_out.ack) begin
			timeouts++;
			$display("timeout: no wishbone ack for register %0d", sel);
		end
		wb_in = '0; // idle between cycles
	endtask

	// status moves while items drain, so read until it settles on the value
	task automatic poll_status(input logic [31:0] expected);
		logic [31:0] rdata;
		int tries;
		tries = 0;
		do begin
			wb_access(1'b0, ADDR_STATUS, 32'h0, rdata);
			tries++;
		end while (rdata !== expected && tries < POLL_LIMIT);
		check("status", expected, rdata);
	endtask

	function automatic int pending();
		int total;
		total = 0;
		for (int p = 0; p < PORT_COUNT; p++)
			total += expect_q[p].size();
		return total;
	endfunction

	// out_ready source with fresh bits #1 after each edge
	initial begin
		logic [31:0] rnd;
		rnd = 32'h60f1;
		out_ready = '0;
		forever begin
			@(posedge clk);
			#1;
			rnd = xorshift(rnd);
			out_ready = (ready_mask == '1) ? rnd[PORT_COUNT-1:0] : ready_mask;
		end
	end

	// transfer monitor sampled mid-cycle where valid and ready are settled
	always @(negedge clk) begin
		if (!reset) begin
			for (int p = 0; p < PORT_COUNT; p++) begin
				if (out_valid[p] && out_ready[p]) begin
					if (expect_q[p].size() == 0) begin
						errors++;
						$display("unexpected item %h on port %0d", out_data[p], p);
					end else begin
						check($sformatf("port%0d data", p),
							32'(expect_q[p].pop_front()), 32'(out_data[p]));
					end
				end
			end
		end
	end

	initial begin
		int fd;
		int code;
		int n;
		byte kind;
		string line;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] rdata;
		wb_word_t w;
		reset = 1'b1;
		wb_in = '0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		check("reset out_valid", 32'h0, 32'(out_valid));
		fd = $fopen("tests/router_trace.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the trace file");
		end else begin
			while (!$feof(fd)) begin
				code = $fscanf(fd, " %c", kind);
				if (code != 1)
					break;
				case (kind)
					"#": code = $fgets(line, fd); // comment line
					"R": begin
						code = $fscanf(fd, "%h %h", a, b);
						w = '0;
						w.route.addr = a[DATA_BITS-1:0];
						w.route.dest = b[DEST_BITS-1:0];
						wb_access(1'b1, ADDR_ROUTE, w, rdata);
					end
					"I": begin
						code = $fscanf(fd, "%h", a);
						w = '0;
						w.item.value = a[DATA_BITS-1:0];
						wb_access(1'b1, ADDR_ITEM, w, rdata);
					end
					"S": begin
						code = $fscanf(fd, "%h", a);
						poll_status(a);
					end
					"E": begin
						code = $fscanf(fd, "%h %h", a, b);
						expect_q[a].push_back(b[DATA_BITS-1:0]);
					end
					"P": begin
						code = $fscanf(fd, "%h", a);
						ready_mask = a[PORT_COUNT-1:0];
					end
					default: begin
						errors++;
						$display("unknown line kind '%c' in the trace", kind);
					end
				endcase
			end
			$fclose(fd);
		end
		n = 0;
		while (pending() != 0 && n < DRAIN_TIMEOUT) begin // let the ports drain
			@(posedge clk);
			n++;
		end
		if (pending() != 0) begin
			timeouts++;
			$display("timeout: %0d expected items never came out", pending());
		end
		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: tests/router_trace.txt
# R addr dest | I item | S status | E port data | P ready_mask, all fields hex
# E queues the value expected next on that port, P 1f means random ready
S 0
R 10 0
R 21 1
R 33 3
R 44 4
R 62 2
R 52 1
E 1 52
I 52
S 0
R 52 4
E 4 52
I 52
S 0
P 1b
E 0 10
E 3 33
E 2 62
E 2 62
E 1 21
E 4 44
E 0 10
E 1 21
E 4 44
E 3 33
E 2 62
I 10
I 33
I 62
I 62
I 21
I 44
I 10
I 21
I 44
I 33
I 62
S 48
P 1f
S 0

// File: list.f
hdl/router_pkg.sv
hdl/wb_ingress.sv
hdl/item_fifo.sv
hdl/route_table.sv
hdl/tx_dispatch.sv
hdl/tx_port.sv
hdl/router_top.sv
tests/router_tb.sv

// File: run.sh
#!/bin/sh
# build and run the router testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module router_tb -f list.f -o router_sim
./obj_dir/router_sim | tee sim.log
grep -q '^>>> PASS$' sim.log
